/* Bender.yml */
package:
  name: bitops_harness

sources:
  # design, in compile order
  - source/bitops_pkg.sv
  - source/shift_lane.sv
  - source/bit_tricks_stage.sv
  - source/onehot_index_stage.sv
  - source/bitops_top.sv

  # testbench
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/bitops_tb.sv

/* files.f */
source/bitops_pkg.sv
source/shift_lane.sv
source/bit_tricks_stage.sv
source/onehot_index_stage.sv
source/bitops_top.sv
verif/tb_clock_gen.sv
verif/bitops_tb.sv

/* source/bit_tricks_stage.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// registered bit tricks for lanes 0 to 2
// negate, isolate rightmost one, clear rightmost one
//////////////////////////////////////////////////////////////////////

module bit_tricks_stage (
    input  logic              clk,
    input  logic              rst_i,
    // held lane words
    input  bitops_pkg::word_t neg_x_i,
    input  bitops_pkg::word_t iso_x_i,
    input  bitops_pkg::word_t clr_x_i,
    // registered results
    output bitops_pkg::word_t neg_o,
    output bitops_pkg::word_t iso_o,
    output bitops_pkg::word_t clr_o
);

    bitops_pkg::word_t neg_d;
    bitops_pkg::word_t iso_d;
    bitops_pkg::word_t clr_d;

    // two's complement, invert and add one
    assign neg_d = ~neg_x_i + bitops_pkg::word_t'(1);

    // x & -x keeps only the lowest set bit
    // the carry of -x stops at that bit, everything below is zero
    assign iso_d = iso_x_i & (~iso_x_i + bitops_pkg::word_t'(1));

    // x & (x-1) drops the lowest set bit
    // the borrow flips that bit and the zeros below it
    assign clr_d = clr_x_i & (clr_x_i - bitops_pkg::word_t'(1));

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            neg_o <= '0;
            iso_o <= '0;
            clr_o <= '0;
        end else begin
            neg_o <= neg_d;
            iso_o <= iso_d;
            clr_o <= clr_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // isolated word is zero or a single bit
    iso_onehot0_a : assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(iso_o)
    ) else $error("bit_tricks_stage: iso_o has more than one bit set");

endmodule : bit_tricks_stage

`default_nettype wire

/* source/bitops_pkg.sv */
`default_nettype none

//////////////////////////////////////////////////////////////////////
// shared widths and word types for the bit-manipulation harness
//////////////////////////////////////////////////////////////////////

package bitops_pkg;

    // lane word width, every lane carries one of these
    localparam int unsigned word_w = 32;

    // bit index width, enough to name any bit of a word
    localparam int unsigned idx_w = $clog2(word_w);

    // number of serial lanes on the pins
    localparam int unsigned num_lanes = 5;

    // control pins
    // bit 0 parallel load, bit 1 shift enable
    localparam int unsigned num_gpi = 2;
    localparam int unsigned gpi_pld = 0;
    localparam int unsigned gpi_sen = 1;

    // one lane word
    typedef logic [word_w-1:0] word_t;

    // bit position inside a word
    typedef logic [idx_w-1:0] idx_t;

    // priority encoder result
    // vld sits in the msb, so it lands on bit idx_w once zero-extended
    typedef struct packed {
        logic vld;
        idx_t idx;
    } enc_t;

    // all lane words side by side, lane 0 in the lowest slice
    typedef word_t [num_lanes-1:0] lane_words_t;

endpackage : bitops_pkg

`default_nettype wire

/* source/bitops_top.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// bit-manipulation harness top
// five serial lanes around two registered compute stages
//////////////////////////////////////////////////////////////////////

module bitops_top (
    // system
    input  logic                                clk,
    input  logic                                rst_i,
    // control pins
    input  logic [bitops_pkg::num_gpi-1:0]      gpi_i,
    // serial lanes
    input  logic [bitops_pkg::num_lanes-1:0]    p_i,
    output logic [bitops_pkg::num_lanes-1:0]    p_o
);

    //////////////////////////////////////////////////////////////////////
    // local signals
    //////////////////////////////////////////////////////////////////////

    // control strobes
    logic sen;
    logic pld;

    // words held in the lanes, and results going back into them
    bitops_pkg::lane_words_t held;
    bitops_pkg::lane_words_t results;

    // narrow results of lanes 3 and 4
    bitops_pkg::idx_t oh_idx;
    bitops_pkg::enc_t enc;

    assign pld = gpi_i[bitops_pkg::gpi_pld];
    assign sen = gpi_i[bitops_pkg::gpi_sen];

    //////////////////////////////////////////////////////////////////////
    // lane array
    //////////////////////////////////////////////////////////////////////

    // instance i owns slice i of held/results and pin i
    shift_lane u_lane [bitops_pkg::num_lanes-1:0] (
        .clk   (clk),
        .rst_i (rst_i),
        .sen_i (sen),
        .pld_i (pld),
        .ser_i (p_i),
        .par_i (results),
        .par_o (held),
        .ser_o (p_o)
    );

    //////////////////////////////////////////////////////////////////////
    // compute stages
    //////////////////////////////////////////////////////////////////////

    // lanes 0 to 2
    bit_tricks_stage u_bit_tricks (
        .clk     (clk),
        .rst_i   (rst_i),
        .neg_x_i (held[0]),
        .iso_x_i (held[1]),
        .clr_x_i (held[2]),
        .neg_o   (results[0]),
        .iso_o   (results[1]),
        .clr_o   (results[2])
    );

    // lanes 3 and 4
    onehot_index_stage u_onehot_index (
        .clk      (clk),
        .rst_i    (rst_i),
        .oh_x_i   (held[3]),
        .dec_x_i  (held[4]),
        .oh_idx_o (oh_idx),
        .enc_o    (enc)
    );

    // zero-extend the narrow results to full lane words
    // vld ends up in bit idx_w of lane 4
    assign results[3] = {{(bitops_pkg::word_w - bitops_pkg::idx_w){1'b0}}, oh_idx};
    assign results[4] = {{(bitops_pkg::word_w - $bits(bitops_pkg::enc_t)){1'b0}}, enc};

endmodule : bitops_top

`default_nettype wire

/* source/onehot_index_stage.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// registered index logic for lanes 3 and 4
// one-hot to index, lowest-set-bit priority encoder
//////////////////////////////////////////////////////////////////////

module onehot_index_stage (
    input  logic              clk,
    input  logic              rst_i,
    // held lane words
    input  bitops_pkg::word_t oh_x_i,
    input  bitops_pkg::word_t dec_x_i,
    // registered results
    output bitops_pkg::idx_t  oh_idx_o,
    output bitops_pkg::enc_t  enc_o
);

    bitops_pkg::idx_t oh_idx_d;
    bitops_pkg::enc_t enc_d;

    //////////////////////////////////////////////////////////////////////
    // one-hot to index
    //////////////////////////////////////////////////////////////////////

    // or together the positions of every set bit
    // exact for a one-hot word, zero for zero, a mix for anything else
    // no priority chain, just an or tree per index bit
    always_comb begin
        oh_idx_d = '0;
        for (int i = 0; i < bitops_pkg::word_w; i++) begin
            if (oh_x_i[i]) begin
                oh_idx_d = oh_idx_d | bitops_pkg::idx_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // priority encoder, lowest index wins
    //////////////////////////////////////////////////////////////////////

    // walk from the top down so the lowest set bit is written last
    always_comb begin
        enc_d = '0;
        for (int i = bitops_pkg::word_w - 1; i >= 0; i--) begin
            if (dec_x_i[i]) begin
                enc_d.vld = 1'b1;
                enc_d.idx = bitops_pkg::idx_t'(i);
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst_i) begin
            oh_idx_o <= '0;
            enc_o    <= '0;
        end else begin
            oh_idx_o <= oh_idx_d;
            enc_o    <= enc_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // vld follows the previous input word one cycle later
    // skip the first edge out of reset, the register was still clearing
    enc_vld_follows_input_a : assert property (
        @(posedge clk) disable iff (rst_i)
        !$past(rst_i) |-> (enc_o.vld == ($past(dec_x_i) != '0))
    ) else $error("onehot_index_stage: enc_o.vld does not match input");

endmodule : onehot_index_stage

`default_nettype wire

/* source/shift_lane.sv */
`timescale 1ns/1ps
`default_nettype none

//////////////////////////////////////////////////////////////////////
// one serial lane
// shift-in on enable, parallel load on strobe, msb out
//////////////////////////////////////////////////////////////////////

module shift_lane (
    input  logic              clk,
    input  logic              rst_i,
    // control strobes
    input  logic              sen_i,
    input  logic              pld_i,
    // serial and parallel data
    input  logic              ser_i,
    input  bitops_pkg::word_t par_i,
    output bitops_pkg::word_t par_o,
    output logic              ser_o
);

    // lane register
    bitops_pkg::word_t lane_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            lane_q <= '0;
        end else if (sen_i) begin
            // shift left, new bit enters at the lsb
            lane_q <= {lane_q[bitops_pkg::word_w-2:0], ser_i};
        end else if (pld_i) begin
            // take the compute result back in
            lane_q <= par_i;
        end
    end

    // word goes to the compute stages
    assign par_o = lane_q;

    // msb leaves first
    assign ser_o = lane_q[bitops_pkg::word_w-1];

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // a load in the middle of a shift would mix two words
    sen_pld_exclusive_a : assert property (
        @(posedge clk) disable iff (rst_i)
        sen_i |-> !pld_i
    ) else $error("shift_lane: sen and pld asserted together");

endmodule : shift_lane

`default_nettype wire

/* verif/bitops_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bitops_tb;

    // number of random transactions
    localparam int num_trans = 200;

    // cycles allowed for reset to drop
    localparam int reset_timeout = 20;

    logic                                clk;
    logic                                rst;
    logic [bitops_pkg::num_gpi-1:0]      gpi;
    logic [bitops_pkg::num_lanes-1:0]    p_in;
    logic [bitops_pkg::num_lanes-1:0]    p_out;

    integer seed = 71;
    int     errors = 0;
    int     checks = 0;

    tb_clock_gen u_clock_gen (
        .clk_o (clk),
        .rst_o (rst)
    );

    bitops_top dut_i (
        .clk   (clk),
        .rst_i (rst),
        .gpi_i (gpi),
        .p_i   (p_in),
        .p_o   (p_out)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    // expected lane result for one input word
    function automatic bitops_pkg::word_t lane_result(input int lane,
                                                     input bitops_pkg::word_t x);
        bitops_pkg::word_t r;
        bitops_pkg::idx_t  pos_or;
        int                low;
        bit                found;
        found  = 1'b0;
        low    = 0;
        pos_or = '0;
        // scan upward so the first hit is the rightmost one
        for (int i = 0; i < bitops_pkg::word_w; i++) begin
            if (x[i]) begin
                pos_or = pos_or | bitops_pkg::idx_t'(i);
                if (!found) begin
                    found = 1'b1;
                    low   = i;
                end
            end
        end
        case (lane)
            // negation as zero minus x
            0: r = bitops_pkg::word_t'(0) - x;
            // keep only the rightmost one
            1: r = found ? (bitops_pkg::word_t'(1) << low) : '0;
            // drop the rightmost one
            2: r = found ? (x ^ (bitops_pkg::word_t'(1) << low)) : x;
            // or of set positions zero-extended
            3: r = bitops_pkg::word_t'(pos_or);
            // vld just above the index field
            4: r = found ? ((bitops_pkg::word_t'(1) << bitops_pkg::idx_w)
                            | bitops_pkg::word_t'(low)) : '0;
            default: r = '0;
        endcase
        return r;
    endfunction

    function automatic string lane_name(input int lane);
        case (lane)
            0: return "p_o[0] neg";
            1: return "p_o[1] iso";
            2: return "p_o[2] clr";
            3: return "p_o[3] oh_idx";
            default: return "p_o[4] enc";
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // stimulus helpers
    //////////////////////////////////////////////////////////////////////

    // inputs move 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // random word from a mix of corner cases
    task automatic pick_word(output bitops_pkg::word_t w);
        int kind;
        int pos;
        kind = $unsigned($random(seed)) % 5;
        pos  = $unsigned($random(seed)) % bitops_pkg::word_w;
        case (kind)
            0: w = $random(seed);
            1: w = bitops_pkg::word_t'(1) << pos;
            2: w = '0;
            3: w = '1;
            // single bit at one end of the word
            default: w = pos[0] ? bitops_pkg::word_t'(1)
                                : (bitops_pkg::word_t'(1) << (bitops_pkg::word_w - 1));
        endcase
    endtask

    // 32 shift cycles with msb first in and out on every lane
    // p_o is read before each shift edge
    task automatic shift_words(input  bitops_pkg::lane_words_t in_words,
                               output bitops_pkg::lane_words_t out_words);
        out_words = '0;
        for (int b = bitops_pkg::word_w - 1; b >= 0; b--) begin
            for (int l = 0; l < bitops_pkg::num_lanes; l++) begin
                out_words[l][b] = p_out[l];
                p_in[l]         = in_words[l][b];
            end
            gpi = '0;
            gpi[bitops_pkg::gpi_sen] = 1'b1;
            next_cycle();
        end
        gpi  = '0;
        p_in = '0;
    endtask

    // shift in and idle before one or more loads and a compared shift out
    // each extra load reapplies the lane functions to the held results
    task automatic run_transaction(input bitops_pkg::lane_words_t words,
                                   input int loads);
        bitops_pkg::lane_words_t expected;
        bitops_pkg::lane_words_t got;
        bitops_pkg::lane_words_t drained;
        expected = words;
        for (int n = 0; n < loads; n++) begin
            for (int l = 0; l < bitops_pkg::num_lanes; l++) begin
                expected[l] = lane_result(l, expected[l]);
            end
        end
        shift_words(words, drained);
        // lanes were emptied by the zeros of the previous shift-out
        checks++;
        if (drained !== bitops_pkg::lane_words_t'(0)) begin
            errors++;
            $display("FAIL p_o during shift-in: expected %h got %h",
                     bitops_pkg::lane_words_t'(0), drained);
        end
        // stage registers catch up with the last shifted word
        gpi = '0;
        next_cycle();
        for (int n = 0; n < loads; n++) begin
            if (n > 0) begin
                gpi = '0;
                next_cycle();
            end
            gpi = '0;
            gpi[bitops_pkg::gpi_pld] = 1'b1;
            next_cycle();
        end
        gpi = '0;
        shift_words('0, got);
        for (int l = 0; l < bitops_pkg::num_lanes; l++) begin
            checks++;
            if (got[l] !== expected[l]) begin
                errors++;
                $display("FAIL %s: in %h loads %0d expected %h got %h",
                         lane_name(l), words[l], loads, expected[l], got[l]);
            end
        end
    endtask

    // bounded loop until reset drops
    task automatic wait_reset_release(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < reset_timeout) begin
            next_cycle();
            if (!rst) begin
                ok = 1'b1;
            end
            cycles++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        bit                      reset_ok;
        bitops_pkg::lane_words_t words;
        int                      loads;
        gpi  = '0;
        p_in = '0;
        wait_reset_release(reset_ok);
        if (!reset_ok) begin
            errors++;
            $display("reset was still asserted after %0d cycles", reset_timeout);
            $display("errors: %0d  checks: %0d", errors, checks);
            $display("** FAIL **");
            $finish;
        end else begin
            // lanes come out of reset empty
            for (int c = 0; c < 40; c++) begin
                checks++;
                if (p_out !== '0) begin
                    errors++;
                    $display("FAIL p_o after reset: cycle %0d expected %h got %h",
                             c, {bitops_pkg::num_lanes{1'b0}}, p_out);
                end
                gpi = '0;
                gpi[bitops_pkg::gpi_sen] = 1'b1;
                next_cycle();
            end
            gpi = '0;
            next_cycle();

            // a few fixed words first with a multi-bit word on lane 3
            run_transaction('0, 1);
            run_transaction('1, 1);
            words = '0;
            words[3] = 32'h0000_0a05;
            words[4] = 32'h8000_0100;
            run_transaction(words, 1);

            // random words where every eighth one loads twice
            for (int t = 0; t < num_trans; t++) begin
                for (int l = 0; l < bitops_pkg::num_lanes; l++) begin
                    pick_word(words[l]);
                end
                loads = (t % 8 == 7) ? 2 : 1;
                run_transaction(words, loads);
            end

            $display("errors: %0d  checks: %0d", errors, checks);
            if (errors == 0) begin
                $display("** PASS **");
            end else begin
                $display("** FAIL **");
            end
            $finish;
        end
    end

endmodule : bitops_tb

`default_nettype wire

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    // 8 ns period
    initial begin
        clk_o = 1'b0;
        forever #4 clk_o = ~clk_o;
    end

    // reset held for 5 rising edges, released on a falling edge
    initial begin
        rst_o = 1'b1;
        repeat (5) @(posedge clk_o);
        @(negedge clk_o);
        rst_o = 1'b0;
    end

endmodule : tb_clock_gen

`default_nettype wire
